/* include/keccak_rc.svh */
`ifndef KECCAK_RC_SVH
`define KECCAK_RC_SVH

// iota constants, one per round
localparam logic [63:0] RC_TABLE [0:23] = '{
   64'h0000_0000_0000_0001, 64'h0000_0000_0000_8082,
   64'h8000_0000_0000_808a, 64'h8000_0000_8000_8000,
   64'h0000_0000_0000_808b, 64'h0000_0000_8000_0001,
   64'h8000_0000_8000_8081, 64'h8000_0000_0000_8009,
   64'h0000_0000_0000_008a, 64'h0000_0000_0000_0088,
   64'h0000_0000_8000_8009, 64'h0000_0000_8000_000a,
   64'h0000_0000_8000_808b, 64'h8000_0000_0000_008b,
   64'h8000_0000_0000_8089, 64'h8000_0000_0000_8003,
   64'h8000_0000_0000_8002, 64'h8000_0000_0000_0080,
   64'h0000_0000_0000_800a, 64'h8000_0000_8000_000a,
   64'h8000_0000_8000_8081, 64'h8000_0000_0000_8080,
   64'h0000_0000_8000_0001, 64'h8000_0000_8000_8008
};

// rho rotation per lane, indexed x+5y
localparam int RHO_TABLE [0:24] = '{
    0,  1, 62, 28, 27,   // y = 0
   36, 44,  6, 55, 20,   // y = 1
    3, 10, 43, 25, 39,   // y = 2
   41, 45, 15, 21,  8,   // y = 3
   18,  2, 61, 56, 14    // y = 4
};

`endif

/* rtl/keccak_pkg.sv */
package keccak_pkg;

   // --------------------
   // permutation geometry
   // --------------------
   localparam int LANE_W     = 64;
   localparam int NUM_LANES  = 25;
   localparam int STATE_W    = LANE_W * NUM_LANES;   // 1600
   localparam int NUM_ROUNDS = 24;

   // sponge rate for the 256-bit security level
   localparam int RATE_W     = 1088;
   localparam int RATE_LANES = RATE_W / LANE_W;      // 17
   localparam int RATE_BYTES = RATE_W / 8;           // 136

   typedef logic [LANE_W-1:0] lane_t;

   // lane[x+5y], lane 0 sits in the low bits
   typedef struct packed {
      lane_t [NUM_LANES-1:0] lane;
   } keccak_state_t;

   `include "keccak_rc.svh"

   function automatic lane_t round_const(input logic [4:0] idx);
      return RC_TABLE[idx];
   endfunction

   function automatic int rho_offset(input int idx);
      return RHO_TABLE[idx];
   endfunction

endpackage

/* rtl/tape_pkg.sv */
package tape_pkg;

   // --------------------
   // request layout
   // --------------------
   // field order is also the message byte order, seed first
   typedef struct packed {
      logic [127:0] seed;
      logic [255:0] salt;
      logic [7:0]   t;
      logic [7:0]   i;
   } tape_req_t;

   localparam int MSG_BYTES = 50;

   // shake domain bits plus first pad bit
   localparam logic [7:0] PAD_FIRST = 8'h1f;
   // final pad bit, or'ed into the last rate byte
   localparam logic [7:0] PAD_LAST  = 8'h80;

   // --------------------
   // output tapes
   // --------------------
   localparam int SQUEEZE_BLOCKS   = 4;
   localparam int LAST_BLOCK_BYTES = 120;   // 3 x 136 + 120 = 528 bytes
   localparam int TAPE_W           = 4224;

   // first squeezed byte in the top byte
   typedef logic [TAPE_W-1:0] tapes_t;

endpackage

/* rtl/keccak_round.sv */
`timescale 1ns/1ps

module keccak_round #(
   parameter int STAGE            = 0,
   parameter int ROUNDS_PER_CYCLE = 2
) (
   input  logic [4:0]                perm_step_i,
   input  keccak_pkg::keccak_state_t state_i,
   output keccak_pkg::keccak_state_t state_o
);
   import keccak_pkg::*;

   logic [4:0] round_idx;
   lane_t      c [5];           // column parity
   lane_t      d [5];
   lane_t      a [NUM_LANES];   // after theta
   lane_t      b [NUM_LANES];   // after rho and pi

   function automatic lane_t rotl(input lane_t v, input int n);
      return (v << n) | (v >> (LANE_W - n));   // n = 0 leaves v unchanged
   endfunction

   // stage k of the chain runs round step*R + k
   assign round_idx = 5'(perm_step_i * ROUNDS_PER_CYCLE + STAGE);

   always_comb begin
      // --------------------
      // theta
      // --------------------
      for (int x = 0; x < 5; x++) begin
         c[x] = state_i.lane[x] ^ state_i.lane[x+5] ^ state_i.lane[x+10]
              ^ state_i.lane[x+15] ^ state_i.lane[x+20];
      end
      for (int x = 0; x < 5; x++) begin
         d[x] = c[(x+4)%5] ^ rotl(c[(x+1)%5], 1);
      end
      for (int y = 0; y < 5; y++) begin
         for (int x = 0; x < 5; x++) begin
            a[x+5*y] = state_i.lane[x+5*y] ^ d[x];
         end
      end

      // --------------------
      // rho and pi
      // --------------------
      // (x,y) moves to (y, 2x+3y)
      for (int y = 0; y < 5; y++) begin
         for (int x = 0; x < 5; x++) begin
            b[y+5*((2*x+3*y)%5)] = rotl(a[x+5*y], rho_offset(x+5*y));
         end
      end

      // --------------------
      // chi and iota
      // --------------------
      for (int y = 0; y < 5; y++) begin
         for (int x = 0; x < 5; x++) begin
            state_o.lane[x+5*y] = b[x+5*y] ^ (~b[(x+1)%5+5*y] & b[(x+2)%5+5*y]);
         end
      end
      state_o.lane[0] = state_o.lane[0] ^ round_const(round_idx);
   end

endmodule

/* rtl/sponge_absorb.sv */
`timescale 1ns/1ps

module sponge_absorb #(
   parameter int ROUNDS_PER_CYCLE = 2
) (
   input  logic                      clk_i,
   input  logic                      reset,
   input  logic                      start_i,
   input  tape_pkg::tape_req_t       req_i,
   input  keccak_pkg::keccak_state_t chain_i,
   output logic                      busy_o,
   output keccak_pkg::keccak_state_t perm_state_o,
   output logic [4:0]                perm_step_o,
   output logic                      block_strobe_o,
   output logic [1:0]                block_idx_o
);
   import keccak_pkg::*;
   import tape_pkg::*;

   localparam int P = NUM_ROUNDS / ROUNDS_PER_CYCLE;   // cycles per permutation

   logic                   busy_q;
   logic [4:0]             step_q;
   logic [1:0]             blk_q;
   logic                   accept;
   logic                   step_last;
   logic [8*MSG_BYTES-1:0] msg;
   logic [RATE_W-1:0]      pad_block;
   keccak_state_t          state_q;

   assign accept    = start_i && !busy_q;   // start while busy is dropped
   assign step_last = (step_q == 5'(P - 1));
   assign msg       = req_i;

   // --------------------
   // padded rate block
   // --------------------
   // byte j of the block lands in state bits [8j +: 8], i.e. little-endian lanes
   always_comb begin
      pad_block = '0;
      for (int j = 0; j < MSG_BYTES; j++) begin
         pad_block[8*j +: 8] = msg[8*(MSG_BYTES-1-j) +: 8];   // seed msb first
      end
      pad_block[8*MSG_BYTES +: 8] = PAD_FIRST;
      pad_block[8*(RATE_BYTES-1) +: 8] = pad_block[8*(RATE_BYTES-1) +: 8] | PAD_LAST;
   end

   // --------------------
   // control
   // --------------------
   always_ff @(posedge clk_i or negedge reset) begin
      if (!reset) begin
         busy_q <= 1'b0;
         step_q <= '0;
         blk_q  <= '0;
      end else if (accept) begin
         busy_q <= 1'b1;
         step_q <= '0;
         blk_q  <= '0;
      end else if (busy_q) begin
         if (step_last) begin
            step_q <= '0;
            blk_q  <= blk_q + 2'd1;   // wraps back to 0 after block 3
            if (blk_q == 2'(SQUEEZE_BLOCKS - 1)) begin
               busy_q <= 1'b0;
            end
         end else begin
            step_q <= step_q + 5'd1;
         end
      end
   end

   // sponge state, absorbed once into zero then permuted in place
   always_ff @(posedge clk_i) begin
      if (accept) begin
         state_q <= keccak_state_t'({{(STATE_W - RATE_W){1'b0}}, pad_block});
      end else if (busy_q) begin
         state_q <= chain_i;
      end
   end

   assign busy_o         = busy_q;
   assign perm_state_o   = state_q;
   assign perm_step_o    = step_q;
   assign block_strobe_o = busy_q && step_last;   // chain holds a full permutation
   assign block_idx_o    = blk_q;

endmodule

/* rtl/tape_squeeze.sv */
`timescale 1ns/1ps

module tape_squeeze (
   input  logic                      clk_i,
   input  logic                      reset,
   input  logic                      block_strobe_i,
   input  logic [1:0]                block_idx_i,
   input  keccak_pkg::keccak_state_t chain_i,
   output logic                      done_o,
   output tape_pkg::tapes_t          tapes_o
);
   import keccak_pkg::*;
   import tape_pkg::*;

   localparam int LAST_W = 8 * LAST_BLOCK_BYTES;   // truncated final block
   localparam int HEAD_W = TAPE_W - LAST_W;        // blocks 0..2

   logic [RATE_W-1:0] rate_le;
   logic [RATE_W-1:0] rate_be;
   logic [HEAD_W-1:0] head_q;
   logic              last_blk;

   assign rate_le  = chain_i.lane[RATE_LANES-1:0];
   assign last_blk = (block_idx_i == 2'(SQUEEZE_BLOCKS - 1));

   // first squeezed byte to the top
   always_comb begin
      for (int j = 0; j < RATE_BYTES; j++) begin
         rate_be[RATE_W-1-8*j -: 8] = rate_le[8*j +: 8];
      end
   end

   // --------------------
   // working register
   // --------------------
   always_ff @(posedge clk_i) begin
      if (block_strobe_i && !last_blk) begin
         head_q[HEAD_W-1-RATE_W*block_idx_i -: RATE_W] <= rate_be;
      end
   end

   always_ff @(posedge clk_i or negedge reset) begin
      if (!reset) begin
         done_o  <= 1'b0;
         tapes_o <= '0;
      end else begin
         done_o <= block_strobe_i && last_blk;
         if (block_strobe_i && last_blk) begin
            tapes_o <= {head_q, rate_be[RATE_W-1 -: LAST_W]};   // last block cut to 120 bytes
         end
      end
   end

endmodule

/* rtl/tape_gen_top.sv */
`timescale 1ns/1ps

module tape_gen_top #(
   parameter int ROUNDS_PER_CYCLE = 2   // must divide 24
) (
   input  logic                clk_i,
   input  logic                reset,
   input  logic                start_i,
   input  tape_pkg::tape_req_t req_i,
   output logic                busy_o,
   output logic                done_o,
   output tape_pkg::tapes_t    tapes_o
);
   import keccak_pkg::*;

   keccak_state_t perm_state;
   keccak_state_t chain_out;
   keccak_state_t stage_state [ROUNDS_PER_CYCLE+1];
   logic [4:0]    perm_step;
   logic          block_strobe;
   logic [1:0]    block_idx;

   sponge_absorb #(
      .ROUNDS_PER_CYCLE (ROUNDS_PER_CYCLE)
   ) absorb_i (
      .clk_i          (clk_i),
      .reset          (reset),
      .start_i        (start_i),
      .req_i          (req_i),
      .chain_i        (chain_out),
      .busy_o         (busy_o),
      .perm_state_o   (perm_state),
      .perm_step_o    (perm_step),
      .block_strobe_o (block_strobe),
      .block_idx_o    (block_idx)
   );

   // --------------------
   // round chain
   // --------------------
   assign stage_state[0] = perm_state;

   for (genvar k = 0; k < ROUNDS_PER_CYCLE; k++) begin : g_round
      keccak_round #(
         .STAGE            (k),
         .ROUNDS_PER_CYCLE (ROUNDS_PER_CYCLE)
      ) round_i (
         .perm_step_i (perm_step),
         .state_i     (stage_state[k]),
         .state_o     (stage_state[k+1])
      );
   end

   assign chain_out = stage_state[ROUNDS_PER_CYCLE];

   tape_squeeze squeeze_i (
      .clk_i          (clk_i),
      .reset          (reset),
      .block_strobe_i (block_strobe),
      .block_idx_i    (block_idx),
      .chain_i        (chain_out),
      .done_o         (done_o),
      .tapes_o        (tapes_o)
   );

endmodule

/* verif/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
   parameter int PERIOD_NS    = 40,
   parameter int RESET_CYCLES = 5
) (
   output logic clk_o,
   output logic reset_o
);

   initial begin
      clk_o = 1'b0;
      forever #(PERIOD_NS / 2) clk_o = ~clk_o;
   end

   // active low, released on a rising edge
   initial begin
      reset_o = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_o);
      reset_o <= 1'b1;
   end

endmodule

/* verif/tape_gen_properties.sv */
`timescale 1ns/1ps

module tape_gen_properties #(
   parameter int ROUNDS_PER_CYCLE = 2
) (
   input logic             clk_i,
   input logic             reset,
   input logic             start_i,
   input logic             busy_o,
   input logic             done_o,
   input tape_pkg::tapes_t tapes_o
);
   localparam int LAT = 4 * (24 / ROUNDS_PER_CYCLE) + 1;   // start edge to done edge

   a_done_pulse: assert property (@(posedge clk_i) disable iff (!reset)
      done_o |=> !done_o)
      else $error("done_o stayed high for more than one cycle");

   a_busy_with_done: assert property (@(posedge clk_i) disable iff (!reset)
      $fell(busy_o) == $rose(done_o))
      else $error("busy_o did not fall in the same cycle as done_o rose");

   // start seen at the accept edge, one edge after it was driven
   a_latency: assert property (@(posedge clk_i) disable iff (!reset)
      (start_i && !busy_o) |=> !done_o [*LAT-1] ##1 done_o)
      else $error("done_o did not follow an accepted start at the expected latency");

   a_tapes_hold: assert property (@(posedge clk_i) disable iff (!reset)
      !$stable(tapes_o) |-> $rose(done_o))
      else $error("tapes_o changed outside the done cycle");

endmodule

/* verif/tb_tape_gen.sv */
`timescale 1ns/1ps

module tb_tape_gen;
   import tape_pkg::*;

   localparam int ROUNDS    = 2;
   localparam int PERIOD    = 40;
   localparam int NUM_VEC   = 4;
   localparam int LAT       = 4 * (24 / ROUNDS) + 1;
   localparam int WATCHDOG  = (NUM_VEC * (LAT + 8 + 10) + 5) * PERIOD;

   logic        clk_i;
   logic        reset;
   logic        start_i;
   tape_req_t   req_i;
   logic        busy_o;
   logic        done_o;
   tapes_t      tapes_o;

   // three words per vector: request, request sent while busy, latency
   logic [399:0] vec_mem [0:3*NUM_VEC-1];

   int     val_errs = 0;
   int     tim_errs = 0;
   int     done_cnt = 0;
   int     acc_idx  = 0;
   int     cnt      = 0;
   int     exp_lat  = 0;
   logic   running  = 1'b0;
   tapes_t exp_tapes;

   tb_clock_gen #(.PERIOD_NS(PERIOD), .RESET_CYCLES(5)) clk_gen_i (
      .clk_o   (clk_i),
      .reset_o (reset)
   );

   tape_gen_top #(.ROUNDS_PER_CYCLE(ROUNDS)) dut_i (.*);

   bind tape_gen_top tape_gen_properties #(.ROUNDS_PER_CYCLE(ROUNDS_PER_CYCLE)) props_i (.*);

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic logic [63:0] rot_left(input logic [63:0] v, input int n);
      if (n == 0) begin
         return v;
      end
      return (v << n) | (v >> (64 - n));
   endfunction

   // --------------------
   // reference sponge
   // --------------------
   function automatic logic [1599:0] keccak_f(input logic [1599:0] s_in);
      logic [63:0]   a [25];
      logic [63:0]   b [25];
      logic [63:0]   c [5];
      int            rho [25];
      logic [63:0]   rc;
      logic [7:0]    lfsr;
      logic [1599:0] s_out;
      int            x;
      int            y;
      int            tmp;
      rho[0] = 0;
      x = 1;
      y = 0;
      for (int t = 0; t < 24; t++) begin   // offsets walk the (x,y) orbit
         rho[x+5*y] = ((t + 1) * (t + 2) / 2) % 64;
         tmp = y;
         y = (2 * x + 3 * y) % 5;
         x = tmp;
      end
      for (int i = 0; i < 25; i++) a[i] = s_in[64*i +: 64];
      lfsr = 8'h01;
      for (int rnd = 0; rnd < 24; rnd++) begin
         for (int i = 0; i < 5; i++) c[i] = a[i] ^ a[i+5] ^ a[i+10] ^ a[i+15] ^ a[i+20];
         for (int i = 0; i < 25; i++) a[i] ^= c[(i+4)%5] ^ rot_left(c[(i+1)%5], 1);
         for (int i = 0; i < 25; i++) begin
            b[i/5 + 5*((2*(i%5) + 3*(i/5)) % 5)] = rot_left(a[i], rho[i]);
         end
         for (int i = 0; i < 25; i++) begin
            a[i] = b[i] ^ (~b[(i%5+1)%5 + 5*(i/5)] & b[(i%5+2)%5 + 5*(i/5)]);
         end
         rc = '0;
         for (int j = 0; j < 7; j++) begin   // x^8+x^6+x^5+x^4+1
            if (lfsr[0]) rc[(1 << j) - 1] = 1'b1;
            lfsr = lfsr[7] ? ({lfsr[6:0], 1'b0} ^ 8'h71) : {lfsr[6:0], 1'b0};
         end
         a[0] ^= rc;
      end
      for (int i = 0; i < 25; i++) s_out[64*i +: 64] = a[i];
      return s_out;
   endfunction

   // shake256 of the 50-byte message, cut to 528 bytes
   function automatic tapes_t shake_tapes(input tape_req_t r);
      logic [1599:0] st;
      logic [399:0]  m;
      tapes_t        out;
      int            n;
      st = '0;
      m  = r;
      for (int j = 0; j < 50; j++) st[8*j +: 8] = m[399-8*j -: 8];
      st[8*50 +: 8]  ^= 8'h1f;
      st[8*135 +: 8] ^= 8'h80;   // end of the 136-byte rate
      n = 0;
      for (int blk = 0; blk < 4; blk++) begin
         st = keccak_f(st);
         for (int j = 0; j < 136 && n < 528; j++) begin
            out[4223-8*n -: 8] = st[8*j +: 8];
            n++;
         end
      end
      return out;
   endfunction

   // start, a second start while busy, then wait up to the edge before done
   task automatic send_request(input tape_req_t r, input tape_req_t other, input int lat);
      @(posedge clk_i);
      start_i <= 1'b1;
      req_i   <= r;
      @(posedge clk_i);
      start_i <= 1'b0;
      repeat (3) @(posedge clk_i);
      start_i <= 1'b1;
      req_i   <= other;
      @(posedge clk_i);
      start_i <= 1'b0;
      repeat (lat - 6) @(posedge clk_i);
   endtask

   // --------------------
   // monitor
   // --------------------
   always @(negedge clk_i) begin
      if (reset) begin
         if (running) cnt++;
         if (done_o) begin
            assert (running) else begin
               $display("done_o pulsed with no request in flight");
               tim_errs++;
            end
            assert (!running || cnt == exp_lat) else begin
               $display("done_o came %0d cycles after start, expected %0d", cnt, exp_lat);
               tim_errs++;
            end
            assert (tapes_o == exp_tapes) else begin
               $display("** Error: tapes_o = %h, expected %h", tapes_o, exp_tapes);
               val_errs++;
            end
            assert (!busy_o) else begin
               $display("** Error: busy_o = %h, expected %h", busy_o, 1'b0);
               val_errs++;
            end
            running = 1'b0;
            done_cnt++;
         end else if (running) begin
            assert (busy_o) else begin
               $display("** Error: busy_o = %h, expected %h", busy_o, 1'b1);
               val_errs++;
            end
            assert (done_cnt != 0 || tapes_o == '0) else begin
               $display("** Error: tapes_o = %h, expected %h", tapes_o, tapes_t'(0));
               val_errs++;
            end
            assert (cnt < exp_lat) else begin
               $display("done_o missing %0d cycles after start", cnt);
               tim_errs++;
               running = 1'b0;
            end
         end else begin
            assert (!busy_o) else begin
               $display("** Error: busy_o = %h, expected %h", busy_o, 1'b0);
               val_errs++;
            end
            assert (done_cnt != 0 || tapes_o == '0) else begin
               $display("** Error: tapes_o = %h, expected %h", tapes_o, tapes_t'(0));
               val_errs++;
            end
         end
         if (start_i && !busy_o) begin   // taken at the next edge
            exp_tapes = shake_tapes(req_i);
            exp_lat   = int'(vec_mem[3*acc_idx+2][7:0]);
            acc_idx++;
            cnt     = 0;
            running = 1'b1;
         end
      end
   end

   // --------------------
   // stimulus
   // --------------------
   initial begin
      logic [31:0] rng;
      int          gap;
      start_i = 1'b0;
      req_i   = '0;
      rng     = 32'h9630_217c;
      $readmemh("verif/tape_gen_input.hex", vec_mem);
      wait (reset === 1'b1);
      for (int v = 0; v < NUM_VEC; v++) begin
         rng = lcg_next(rng);
         gap = (v == 1) ? 0 : int'(rng[18:16]);   // vector 1 goes in the done cycle
         repeat (gap) @(posedge clk_i);
         send_request(vec_mem[3*v], vec_mem[3*v+1], int'(vec_mem[3*v+2][7:0]));
      end
      wait (done_cnt == NUM_VEC);
      repeat (4) @(posedge clk_i);
      $display("%0d value errors, %0d timing errors, %0d of %0d requests done",
               val_errs, tim_errs, done_cnt, NUM_VEC);
      if (val_errs == 0 && tim_errs == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG);
      $display("timeout after %0d ns with %0d of %0d requests done", WATCHDOG, done_cnt,
               NUM_VEC);
      $display("%0d value errors, %0d timing errors", val_errs, tim_errs);
      $display("TEST FAIL");
      $finish;
   end

endmodule

/* verif/tape_gen_input.hex */
// columns: request {seed, salt, t, i}, request pulsed while busy, done latency in cycles
// one vector per line
000102030405060708090a0b0c0d0e0f101112131415161718191a1b1c1d1e1f202122232425262728292a2b2c2d2e2f0000 1 31
0 5a 31
0123456789abcdef0123456789abcdefdeadbeefdeadbeefdeadbeefdeadbeefdeadbeefdeadbeefdeadbeefdeadbeef05a3 0 31
fedcba9876543210fedcba9876543210c3a5c3a5c3a5c3a5c3a5c3a5c3a5c3a5c3a5c3a5c3a5c3a5c3a5c3a5c3a5c3a5ff01 123456789 31

/* vlog.f */
+incdir+include
rtl/keccak_pkg.sv
rtl/tape_pkg.sv
rtl/keccak_round.sv
rtl/sponge_absorb.sv
rtl/tape_squeeze.sv
rtl/tape_gen_top.sv
verif/tb_clock_gen.sv
verif/tape_gen_properties.sv
verif/tb_tape_gen.sv

/* Bender.yml */
package:
  name: tape_gen

sources:
  - include_dirs:
      - include
    files:
      - rtl/keccak_pkg.sv
      - rtl/tape_pkg.sv
      - rtl/keccak_round.sv
      - rtl/sponge_absorb.sv
      - rtl/tape_squeeze.sv
      - rtl/tape_gen_top.sv
  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/tape_gen_properties.sv
      - verif/tb_tape_gen.sv
